// ==== project.f ====
verilog/bus_guard_pkg.sv
verilog/bus_guard_if.sv
verilog/mem_bus_guard.sv
verilog/block_ram.sv
verilog/bus_guard_top.sv
verification/bus_guard_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bus guard testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module bus_guard_tb \
	-f project.f --Mdir obj_dir -o bus_guard_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/bus_guard_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

// ==== verification/bus_guard_tb.sv ====
`default_nettype none

module bus_guard_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// About 60 transactions of up to 10 cycles each, with a wide margin.
	localparam int MAX_CYCLES = 2000;
	localparam int MAX_WAIT = 10;
	localparam int RANDOM_OPS = 40;

	logic clk;
	logic arst_n;
	logic instr_rd_req;
	bus_guard_pkg::addr_t instr_rd_addr;
	logic instr_rd_cmd_accepted;
	logic instr_rd_valid;
	bus_guard_pkg::data_t instr_rd_rdata;
	logic data_rd_req;
	bus_guard_pkg::addr_t data_rd_addr;
	logic data_rd_cmd_accepted;
	logic data_rd_valid;
	bus_guard_pkg::data_t data_rd_rdata;
	logic wr_req;
	bus_guard_pkg::addr_t wr_addr;
	bus_guard_pkg::data_t wr_wdata;
	logic wr_cmd_accepted;
	logic wr_valid;

	// Expected memory contents, and which words hold known data.
	bus_guard_pkg::data_t model [bus_guard_pkg::MEM_DEPTH];
	logic written [bus_guard_pkg::MEM_DEPTH];

	string hs_names [6] = '{"instr_rd_cmd_accepted", "data_rd_cmd_accepted",
		"wr_cmd_accepted", "instr_rd_valid", "data_rd_valid", "wr_valid"};
	int seed = 53;
	int err_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_count = 0;
	logic instr_only = 1'b0;

	bus_guard_top dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial
	begin
		while (cycle_count < MAX_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("tests failed");
		$finish;
	end

	// Other ports stay quiet while only the fetch port is used.
	always @(negedge clk)
	begin
		if (instr_only)
		begin
			check_bit("data_rd_valid", data_rd_valid, 1'b0);
			check_bit("wr_valid", wr_valid, 1'b0);
		end
	end

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected)
		begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
			err_count++;
		end
	endtask

	task automatic check_data(input string name, input bus_guard_pkg::data_t got,
		input bus_guard_pkg::data_t expected);
		if (got !== expected)
		begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
			err_count++;
		end
	endtask

	// Index 0..2 is cmd_accepted, 3..5 is valid; fetch, data read, write.
	function automatic logic handshake(input int sel);
		case (sel)
		0: return instr_rd_cmd_accepted;
		1: return data_rd_cmd_accepted;
		2: return wr_cmd_accepted;
		3: return instr_rd_valid;
		4: return data_rd_valid;
		default: return wr_valid;
		endcase
	endfunction

	task automatic wait_for(input int sel, output int n);
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!handshake(sel) && n <= MAX_WAIT);
		if (!handshake(sel))
		begin
			$display("No response: %s stayed low for %0d cycles", hs_names[sel], n);
			err_count++;
			n = 0;
		end
	endtask

	// One complete transaction on port p (0 fetch, 1 data read, 2 write).
	task automatic access(input int p, input bus_guard_pkg::addr_t a,
		input bus_guard_pkg::data_t d);
		int n;
		@(negedge clk);
		instr_rd_req = (p == 0);
		data_rd_req = (p == 1);
		wr_req = (p == 2);
		instr_rd_addr = a;
		data_rd_addr = a;
		wr_addr = a;
		wr_wdata = d;
		wait_for(p, n);
		instr_rd_req = 1'b0;
		data_rd_req = 1'b0;
		wr_req = 1'b0;
		if (n > 0)
		begin
			if (p == 2)
			begin
				model[a] = d;
				written[a] = 1'b1;
			end
			wait_for(p + 3, n);
			if (n > 0 && n != 2)
			begin
				$display("Wrong latency: %s came %0d cycles after accept, expected 2",
					hs_names[p + 3], n);
				err_count++;
			end
			if (p == 0)
				check_data("instr_rd_rdata", instr_rd_rdata, model[a]);
			if (p == 1)
				check_data("data_rd_rdata", data_rd_rdata, model[a]);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (err_count == errs_before)
			$display("Test %0d %s: PASS", tests_run, name);
		else
		begin
			tests_failed++;
			$display("Test %0d %s: FAIL with %0d errors", tests_run, name,
				err_count - errs_before);
		end
	endtask

	task automatic test_reset_state();
		int e;
		int s;
		e = err_count;
		repeat (5)
		begin
			@(negedge clk);
			for (s = 0; s < 6; s++)
				check_bit(hs_names[s], handshake(s), 1'b0);
		end
		report_test("reset state", e);
	endtask

	task automatic test_write_read();
		int e;
		int i;
		e = err_count;
		for (i = 0; i < 8; i++)
			access(2, bus_guard_pkg::addr_t'(2 * i), {$random(seed), $random(seed)});
		for (i = 0; i < 8; i++)
			access(1, bus_guard_pkg::addr_t'(2 * i), '0);
		report_test("write then data read", e);
	endtask

	task automatic test_instr_read();
		int e;
		int i;
		e = err_count;
		// Let the last data read valid pulse end before watching the other ports.
		@(negedge clk);
		instr_only = 1'b1;
		for (i = 0; i < 8; i++)
			access(0, bus_guard_pkg::addr_t'(2 * i), '0);
		instr_only = 1'b0;
		report_test("instruction read", e);
	endtask

	// All three ports request at once; acceptances and valids follow in priority order.
	task automatic test_priority();
		int e;
		int c;
		int s;
		bus_guard_pkg::data_t old_d;
		bus_guard_pkg::data_t new_d;
		e = err_count;
		old_d = model[4];
		new_d = {$random(seed), $random(seed)};
		@(negedge clk);
		instr_rd_req = 1'b1;
		instr_rd_addr = 8'd2;
		data_rd_req = 1'b1;
		data_rd_addr = 8'd4;
		wr_req = 1'b1;
		wr_addr = 8'd4;
		wr_wdata = new_d;
		for (c = 1; c <= 6; c++)
		begin
			@(negedge clk);
			for (s = 0; s < 6; s++)
				check_bit(hs_names[s], handshake(s), (c == ((s < 3) ? s + 1 : s)));
			if (instr_rd_cmd_accepted)
				instr_rd_req = 1'b0;
			if (data_rd_cmd_accepted)
				data_rd_req = 1'b0;
			if (wr_cmd_accepted)
				wr_req = 1'b0;
			if (c == 3)
				check_data("instr_rd_rdata", instr_rd_rdata, model[2]);
			if (c == 4)
				check_data("data_rd_rdata", data_rd_rdata, old_d);
		end
		instr_rd_req = 1'b0;
		data_rd_req = 1'b0;
		wr_req = 1'b0;
		model[4] = new_d;
		report_test("priority", e);
	endtask

	// Back-to-back reads and writes; responses are matched in acceptance order.
	task automatic test_random_traffic();
		int e;
		int issued;
		int cyc;
		int wait_cnt;
		int due;
		logic active;
		logic is_wr;
		logic [31:0] rnd;
		bus_guard_pkg::addr_t a;
		bus_guard_pkg::data_t d;
		bus_guard_pkg::data_t expected;
		bus_guard_pkg::data_t rd_exp_q [$];
		int rd_due_q [$];
		int wr_due_q [$];
		e = err_count;
		issued = 0;
		cyc = 0;
		wait_cnt = 0;
		active = 1'b0;
		is_wr = 1'b0;
		a = '0;
		d = '0;
		@(negedge clk);
		while (issued < RANDOM_OPS || active || rd_due_q.size() > 0 || wr_due_q.size() > 0)
		begin
			if (!active && issued < RANDOM_OPS)
			begin
				rnd = $random(seed);
				a = {4'd0, rnd[3:0]};
				is_wr = rnd[4] | !written[a];
				d = {$random(seed), $random(seed)};
				wr_req = is_wr;
				wr_addr = a;
				wr_wdata = d;
				data_rd_req = !is_wr;
				data_rd_addr = a;
				active = 1'b1;
				wait_cnt = 0;
				issued++;
			end
			else if (!active)
			begin
				wr_req = 1'b0;
				data_rd_req = 1'b0;
			end
			@(negedge clk);
			cyc++;
			if (data_rd_valid)
			begin
				if (rd_due_q.size() == 0)
				begin
					$display("Unexpected data_rd_valid pulse with no read in flight");
					err_count++;
				end
				else
				begin
					expected = rd_exp_q.pop_front();
					due = rd_due_q.pop_front();
					if (cyc != due)
					begin
						$display("Wrong latency: data_rd_valid at cycle %0d, expected %0d",
							cyc, due);
						err_count++;
					end
					check_data("data_rd_rdata", data_rd_rdata, expected);
				end
			end
			if (wr_valid)
			begin
				if (wr_due_q.size() == 0)
				begin
					$display("Unexpected wr_valid pulse with no write in flight");
					err_count++;
				end
				else
				begin
					due = wr_due_q.pop_front();
					if (cyc != due)
					begin
						$display("Wrong latency: wr_valid at cycle %0d, expected %0d",
							cyc, due);
						err_count++;
					end
				end
			end
			if (rd_due_q.size() > 0 && rd_due_q[0] < cyc)
			begin
				$display("No response: a read got no data_rd_valid");
				err_count++;
				expected = rd_exp_q.pop_front();
				due = rd_due_q.pop_front();
			end
			if (wr_due_q.size() > 0 && wr_due_q[0] < cyc)
			begin
				$display("No response: a write got no wr_valid");
				err_count++;
				due = wr_due_q.pop_front();
			end
			if (active)
			begin
				if (is_wr ? wr_cmd_accepted : data_rd_cmd_accepted)
				begin
					active = 1'b0;
					if (is_wr)
					begin
						model[a] = d;
						written[a] = 1'b1;
						wr_due_q.push_back(cyc + 2);
					end
					else
					begin
						rd_exp_q.push_back(model[a]);
						rd_due_q.push_back(cyc + 2);
					end
				end
				else
				begin
					wait_cnt++;
					if (wait_cnt > MAX_WAIT)
					begin
						$display("No response: request %0d was never accepted", issued);
						err_count++;
						active = 1'b0;
						issued = RANDOM_OPS;
					end
				end
			end
		end
		wr_req = 1'b0;
		data_rd_req = 1'b0;
		report_test("pipelined random traffic", e);
	endtask

	initial
	begin
		int i;
		instr_rd_req = 1'b0;
		instr_rd_addr = '0;
		data_rd_req = 1'b0;
		data_rd_addr = '0;
		wr_req = 1'b0;
		wr_addr = '0;
		wr_wdata = '0;
		arst_n = 1'b0;
		for (i = 0; i < bus_guard_pkg::MEM_DEPTH; i++)
			written[i] = 1'b0;
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		test_reset_state();
		test_write_read();
		test_instr_read();
		test_priority();
		test_random_traffic();
		$display("Summary: %0d run, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule : bus_guard_tb

`default_nettype wire

// ==== verilog/bus_guard_top.sv ====
`default_nettype none

module bus_guard_top
(
	input logic clk,
	input logic arst_n,

	input logic instr_rd_req,
	input bus_guard_pkg::addr_t instr_rd_addr,
	output logic instr_rd_cmd_accepted,
	output logic instr_rd_valid,
	output bus_guard_pkg::data_t instr_rd_rdata,

	input logic data_rd_req,
	input bus_guard_pkg::addr_t data_rd_addr,
	output logic data_rd_cmd_accepted,
	output logic data_rd_valid,
	output bus_guard_pkg::data_t data_rd_rdata,

	input logic wr_req,
	input bus_guard_pkg::addr_t wr_addr,
	input bus_guard_pkg::data_t wr_wdata,
	output logic wr_cmd_accepted,
	output logic wr_valid
);

	read_req_if instr_rd_bus();
	read_req_if data_rd_bus();
	write_req_if data_wr_bus();
	mem_port_if mem_bus();

	// Instruction fetch port.
	assign instr_rd_bus.req = instr_rd_req;
	assign instr_rd_bus.addr = instr_rd_addr;
	assign instr_rd_cmd_accepted = instr_rd_bus.cmd_accepted;
	assign instr_rd_valid = instr_rd_bus.valid;
	assign instr_rd_rdata = instr_rd_bus.rdata;

	// Data read port.
	assign data_rd_bus.req = data_rd_req;
	assign data_rd_bus.addr = data_rd_addr;
	assign data_rd_cmd_accepted = data_rd_bus.cmd_accepted;
	assign data_rd_valid = data_rd_bus.valid;
	assign data_rd_rdata = data_rd_bus.rdata;

	// Data write port.
	assign data_wr_bus.req = wr_req;
	assign data_wr_bus.addr = wr_addr;
	assign data_wr_bus.wdata = wr_wdata;
	assign wr_cmd_accepted = data_wr_bus.cmd_accepted;
	assign wr_valid = data_wr_bus.valid;

	mem_bus_guard u_guard
	(
		.clk(clk),
		.arst_n(arst_n),
		.instr_rd(instr_rd_bus),
		.data_rd(data_rd_bus),
		.data_wr(data_wr_bus),
		.mem(mem_bus)
	);

	block_ram u_ram
	(
		.clk(clk),
		.arst_n(arst_n),
		.port(mem_bus)
	);

endmodule : bus_guard_top

`default_nettype wire

// ==== verilog/block_ram.sv ====
`default_nettype none

module block_ram
(
	input logic clk,
	input logic arst_n,
	mem_port_if.memory port
);

	bus_guard_pkg::data_t mem_q [bus_guard_pkg::MEM_DEPTH];

	// Storage and read port.
	// Both act on the same edge the request is seen.
	always_ff @(posedge clk)
	begin
		if (port.req)
		begin
			if (port.acc_type == bus_guard_pkg::MEM_WRITE)
			begin
				mem_q[port.addr] <= port.wdata;
			end
			else
			begin
				port.rdata <= mem_q[port.addr];
			end
		end
	end

	// Every request is answered one cycle later.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			port.valid <= 1'b0;
		end
		else
		begin
			port.valid <= port.req;
		end
	end

endmodule : block_ram

`default_nettype wire

// ==== verilog/mem_bus_guard.sv ====
`default_nettype none

module mem_bus_guard
(
	input logic clk,
	input logic arst_n,
	read_req_if.guard instr_rd,
	read_req_if.guard data_rd,
	write_req_if.guard data_wr,
	mem_port_if.guard mem
);

	// Request chosen this cycle, and the types held in stages 0 and 1.
	bus_guard_pkg::req_type_e sel_type;
	bus_guard_pkg::req_type_e stage0_type;
	bus_guard_pkg::req_type_e stage1_type;

	// Fixed priority: instruction reads, then data reads, then writes.
	always_comb
	begin
		if (instr_rd.req)
		begin
			sel_type = bus_guard_pkg::REQ_READ_INSTR;
		end
		else if (data_rd.req)
		begin
			sel_type = bus_guard_pkg::REQ_READ_DATA;
		end
		else if (data_wr.req)
		begin
			sel_type = bus_guard_pkg::REQ_WRITE_DATA;
		end
		else
		begin
			sel_type = bus_guard_pkg::REQ_NONE;
		end
	end

	// Stage 0 control.
	// Accept one request and raise the memory request for one cycle.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			stage0_type <= bus_guard_pkg::REQ_NONE;
			mem.req <= 1'b0;
			instr_rd.cmd_accepted <= 1'b0;
			data_rd.cmd_accepted <= 1'b0;
			data_wr.cmd_accepted <= 1'b0;
		end
		else
		begin
			stage0_type <= sel_type;
			mem.req <= (sel_type != bus_guard_pkg::REQ_NONE);
			instr_rd.cmd_accepted <= (sel_type == bus_guard_pkg::REQ_READ_INSTR);
			data_rd.cmd_accepted <= (sel_type == bus_guard_pkg::REQ_READ_DATA);
			data_wr.cmd_accepted <= (sel_type == bus_guard_pkg::REQ_WRITE_DATA);
		end
	end

	// Stage 0 payload.
	// Address, access type and write data only matter while mem.req is high.
	always_ff @(posedge clk)
	begin
		case (sel_type)
		bus_guard_pkg::REQ_READ_INSTR:
		begin
			mem.addr <= instr_rd.addr;
			mem.acc_type <= bus_guard_pkg::MEM_READ;
		end

		bus_guard_pkg::REQ_READ_DATA:
		begin
			mem.addr <= data_rd.addr;
			mem.acc_type <= bus_guard_pkg::MEM_READ;
		end

		bus_guard_pkg::REQ_WRITE_DATA:
		begin
			mem.addr <= data_wr.addr;
			mem.wdata <= data_wr.wdata;
			mem.acc_type <= bus_guard_pkg::MEM_WRITE;
		end

		default:
		begin
			// The bus keeps its last values while idle.
		end
		endcase
	end

	// Stage 1 waits one cycle while the RAM answers.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			stage1_type <= bus_guard_pkg::REQ_NONE;
		end
		else
		begin
			stage1_type <= stage0_type;
		end
	end

	// Stage 2 control.
	// Pulse valid on the port that owns the finished request.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			instr_rd.valid <= 1'b0;
			data_rd.valid <= 1'b0;
			data_wr.valid <= 1'b0;
		end
		else
		begin
			instr_rd.valid <= (stage1_type == bus_guard_pkg::REQ_READ_INSTR);
			data_rd.valid <= (stage1_type == bus_guard_pkg::REQ_READ_DATA);
			data_wr.valid <= (stage1_type == bus_guard_pkg::REQ_WRITE_DATA);
		end
	end

	// Stage 2 read data.
	// Each read port holds its word until its next read completes.
	always_ff @(posedge clk)
	begin
		if (stage1_type == bus_guard_pkg::REQ_READ_INSTR)
		begin
			instr_rd.rdata <= mem.rdata;
		end

		if (stage1_type == bus_guard_pkg::REQ_READ_DATA)
		begin
			data_rd.rdata <= mem.rdata;
		end
	end

endmodule : mem_bus_guard

`default_nettype wire

// ==== verilog/bus_guard_if.sv ====
`default_nettype none

// Read request port between a requester and the guard.
interface read_req_if;

	logic req;
	bus_guard_pkg::addr_t addr;
	logic cmd_accepted;
	logic valid;
	bus_guard_pkg::data_t rdata;

	modport requester
	(
		output req, addr,
		input cmd_accepted, valid, rdata
	);

	modport guard
	(
		input req, addr,
		output cmd_accepted, valid, rdata
	);

endinterface : read_req_if

// Write request port; completion comes back on valid alone.
interface write_req_if;

	logic req;
	bus_guard_pkg::addr_t addr;
	bus_guard_pkg::data_t wdata;
	logic cmd_accepted;
	logic valid;

	modport requester
	(
		output req, addr, wdata,
		input cmd_accepted, valid
	);

	modport guard
	(
		input req, addr, wdata,
		output cmd_accepted, valid
	);

endinterface : write_req_if

// The single memory port owned by the guard.
interface mem_port_if;

	logic req;
	bus_guard_pkg::addr_t addr;
	bus_guard_pkg::data_t wdata;
	bus_guard_pkg::mem_acc_e acc_type;
	logic valid;
	bus_guard_pkg::data_t rdata;

	modport guard
	(
		output req, addr, wdata, acc_type,
		input valid, rdata
	);

	modport memory
	(
		input req, addr, wdata, acc_type,
		output valid, rdata
	);

endinterface : mem_port_if

`default_nettype wire

// ==== verilog/bus_guard_pkg.sv ====
`default_nettype none

package bus_guard_pkg;

	// Word address and data widths of the memory port.
	localparam int ADDR_W = 8;
	localparam int DATA_W = 64;

	// One RAM word for every address.
	localparam int MEM_DEPTH = 1 << ADDR_W;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// Request type carried down the guard pipeline.
	// REQ_NONE marks an empty stage.
	typedef enum logic [1:0]
	{
		REQ_NONE,
		REQ_READ_INSTR,
		REQ_READ_DATA,
		REQ_WRITE_DATA
	} req_type_e;

	// Access type seen by the RAM.
	typedef enum logic [0:0]
	{
		MEM_READ,
		MEM_WRITE
	} mem_acc_e;

endpackage : bus_guard_pkg

`default_nettype wire
